// File: bench/histTb.sv
`include "histCfg.svh"

module histTb import linkPkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_HALF     = 20;
    localparam int BINS         = 1 << `HIST_BIN_BITS;
    localparam int COUNT_MAX    = (1 << `COUNT_BITS) - 1;
    localparam int BIN_SHIFT    = `TDC_BITS - `HIST_BIN_BITS;
    localparam int NUM_FRAMES   = 8;
    localparam int CLEAR_CYCLES = `HIST_PIXELS * BINS;
    localparam int MAX_SAMPLES  = 72;   // largest frame in the saturation test
    localparam int STALL_CYCLES = 200;
    localparam int BUDGET       = 3 * (NUM_FRAMES * (CLEAR_CYCLES + MAX_SAMPLES
                                  + `HIST_PIXELS * 20) + STALL_CYCLES);

    logic                      clk;
    logic                      res;
    logic                      inValid;
    linkOp                     inOp;
    logic [`PIXEL_BITS-1:0]    inPixel;
    logic [`TDC_BITS-1:0]      inTdc;
    logic                      inCredit;
    logic                      outValid;
    logic [`PIXEL_BITS-1:0]    outPixel;
    logic [`HIST_BIN_BITS-1:0] outBin;
    logic [`COUNT_BITS-1:0]    outCount;
    logic                      outCredit = 1'b0;
    logic                      holdCredit = 1'b0;   // receiver withholds credit returns

    int    seed;
    int    inCredits;    // sender's view of the input link
    int    outCredits;   // credits the egress should hold
    int    owed;         // results received but not yet credited back
    string testName = "reset";
    int    model [`HIST_PIXELS][BINS];
    int    expPixel [$];
    int    expBin [$];
    int    expCount [$];

    histTop dut (
        .clk(clk), .res(res), .inValid(inValid), .inOp(inOp), .inPixel(inPixel),
        .inTdc(inTdc), .inCredit(inCredit), .outValid(outValid), .outPixel(outPixel),
        .outBin(outBin), .outCount(outCount), .outCredit(outCredit)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic abortRun(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic valueError(input string what, input int expected, input int actual);
        abortRun($sformatf("** Error [%s] %s: expected %0d, actual %0d",
            testName, what, expected, actual));
    endtask

    always @(posedge clk) begin
        if (!res) begin
            inCredits  <= `IN_CREDITS;
            outCredits <= `OUT_CREDITS;
        end else begin
            inCredits  <= inCredits - int'(inValid) + int'(inCredit);
            outCredits <= outCredits - int'(outValid) + int'(outCredit);
        end
    end

    // result receiver returning one credit per cycle
    always @(posedge clk) begin
        if (!res) begin
            owed = 0;
            outCredit <= 1'b0;
        end else begin
            owed = owed + int'(outValid);
            if (!holdCredit && owed > 0) begin
                owed = owed - 1;
                outCredit <= 1'b1;
            end else begin
                outCredit <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (res && outValid) begin
            assert (expPixel.size() != 0)
                else abortRun("a result appeared on the output link outside any frame scan");
            assert (int'(outPixel) == expPixel[0])
                else valueError("pixel", expPixel[0], int'(outPixel));
            assert (int'(outBin) == expBin[0])
                else valueError("peak bin", expBin[0], int'(outBin));
            assert (int'(outCount) == expCount[0])
                else valueError("peak count", expCount[0], int'(outCount));
            void'(expPixel.pop_front());
            void'(expBin.pop_front());
            void'(expCount.pop_front());
        end
    end

    assert property (@(posedge clk) disable iff (!res) !(outValid && outCredits == 0))
        else abortRun("outValid rose while the egress held no output credit");
    assert property (@(posedge clk) disable iff (!res) inCredits <= `IN_CREDITS)
        else abortRun("inCredit returned more credits than the input link owns");

    // first highest bin per pixel and then a clean model for the next frame
    task automatic closeFrame();
        int best;
        int bestBin;
        for (int p = 0; p < `HIST_PIXELS; p++) begin
            best = 0;
            bestBin = 0;
            for (int b = 0; b < BINS; b++) begin
                if (model[p][b] > best) begin
                    best = model[p][b];
                    bestBin = b;
                end
                model[p][b] = 0;
            end
            expPixel.push_back(p);
            expBin.push_back(bestBin);
            expCount.push_back(best);
        end
    endtask

    task automatic sendWord(input linkOp op, input int pixel, input int tdc);
        int bin;
        bin = tdc >> BIN_SHIFT;
        @(posedge clk);
        while (inCredits - int'(inValid) <= 0) begin   // word in flight still owes a credit
            inValid <= 1'b0;
            @(posedge clk);
        end
        inValid <= 1'b1;
        inOp    <= op;
        inPixel <= `PIXEL_BITS'(pixel);
        inTdc   <= `TDC_BITS'(tdc);
        if (op == opSample) begin
            if (model[pixel][bin] < COUNT_MAX) begin
                model[pixel][bin]++;
            end
        end else begin
            closeFrame();
        end
    endtask

    task automatic sendBin(input int pixel, input int bin, input int reps);
        int low;
        for (int i = 0; i < reps; i++) begin
            low = $unsigned($random(seed)) % (1 << BIN_SHIFT);   // low tdc bits are noise
            sendWord(opSample, pixel, (bin << BIN_SHIFT) | low);
        end
    endtask

    task automatic sendRandom(input int count);
        int pixel;
        int tdc;
        for (int i = 0; i < count; i++) begin
            pixel = $unsigned($random(seed)) % `HIST_PIXELS;
            tdc = $unsigned($random(seed)) % (1 << `TDC_BITS);
            sendWord(opSample, pixel, tdc);
        end
    endtask

    task automatic idleCycles(input int count);
        @(posedge clk);
        inValid <= 1'b0;
        repeat (count - 1) @(posedge clk);
    endtask

    task automatic drainResults();
        idleCycles(1);
        while (expPixel.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    initial begin
        #(BUDGET * 2 * CLK_HALF);
        abortRun($sformatf("watchdog expired after %0d cycles, the DUT stopped responding",
            BUDGET));
    end

    initial begin
        seed    = 91258;
        res     = 1'b0;
        inValid = 1'b0;
        inOp    = opSample;
        inPixel = '0;
        inTdc   = '0;
        repeat (3) @(posedge clk);
        res <= 1'b1;

        testName = "randomFrame";
        sendRandom(48);
        sendWord(opFrameEnd, 0, 0);
        drainResults();

        testName = "forwardAndTies";
        sendBin(1, 5, 5);   // back to back to the same address
        sendBin(1, 9, 5);   // equal count so bin 5 stays
        sendBin(2, 12, 3);
        sendBin(2, 3, 3);
        for (int i = 0; i < 4; i++) begin
            sendBin(3, 7, 1);
            sendBin(3, 8, 1);
        end
        sendWord(opFrameEnd, 0, 0);
        drainResults();

        testName = "clearBetweenFrames";
        sendBin(0, 2, 6);
        sendBin(1, 7, 4);
        sendBin(2, 15, 3);
        sendBin(3, 0, 5);
        sendWord(opFrameEnd, 0, 0);
        drainResults();
        sendBin(0, 3, 2);
        sendBin(1, 8, 1);
        sendBin(2, 14, 2);
        sendBin(3, 1, 1);
        sendWord(opFrameEnd, 0, 0);
        drainResults();

        testName = "saturation";
        sendBin(3, 10, 70);
        sendBin(0, 4, 2);
        sendWord(opFrameEnd, 0, 0);
        drainResults();

        // first frame fills buffer and credits and the second frame stalls the scan
        testName = "backPressure";
        @(posedge clk);
        holdCredit <= 1'b1;
        sendRandom(20);
        sendWord(opFrameEnd, 0, 0);
        sendBin(0, 6, 4);
        sendBin(3, 11, 2);
        sendWord(opFrameEnd, 0, 0);
        sendBin(1, 2, 3);   // parked in the fifo behind the stalled scan
        idleCycles(STALL_CYCLES);
        assert (inCredits == `IN_CREDITS - 3)
            else valueError("input credits during stall", `IN_CREDITS - 3, inCredits);
        holdCredit <= 1'b0;
        drainResults();

        testName = "finalFrame";
        sendBin(1, 2, 1);
        sendRandom(10);
        sendWord(opFrameEnd, 0, 0);
        drainResults();
        assert (inCredits == `IN_CREDITS)
            else valueError("input credits at idle", `IN_CREDITS, inCredits);

        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: hw/histBuilder.sv
`include "histCfg.svh"

module histBuilder import linkPkg::*, histPkg::*; (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      fifoValid,
    input  linkOp                     fifoOp,
    input  logic [`PIXEL_BITS-1:0]    fifoPixel,
    input  logic [`TDC_BITS-1:0]      fifoTdc,
    output logic                      fifoPop,
    output logic                      ramRdEn,
    output logic [`RAM_ADDR_BITS-1:0] ramRdAddr,
    input  logic [`COUNT_BITS-1:0]    ramRdData,
    output logic                      ramWrEn,
    output logic [`RAM_ADDR_BITS-1:0] ramWrAddr,
    output logic [`COUNT_BITS-1:0]    ramWrData,
    output logic                      resValid,
    output logic [`PIXEL_BITS-1:0]    resPixel,
    output logic [`HIST_BIN_BITS-1:0] resBin,
    output logic [`COUNT_BITS-1:0]    resCount,
    input  logic                      resFull
);
    buildState state;

    // increment pipeline, stage 1 reads and stage 2 writes back
    logic                      s1Valid;
    logic [`RAM_ADDR_BITS-1:0] s1Addr;
    logic                      s2Valid;
    logic [`RAM_ADDR_BITS-1:0] s2Addr;
    logic                      fwdHit;   // stage 2 must use last cycle's write data
    logic [`COUNT_BITS-1:0]    fwdData;
    logic [`COUNT_BITS-1:0]    oldCount;

    // clear and scan position
    logic [`PIXEL_BITS-1:0]    scanPixel;
    logic [`HIST_BIN_BITS-1:0] scanBin;
    logic                      lastBin;
    logic                      lastPixel;

    // peak search, one compare per returned bin
    logic                      cmpValid;
    logic [`HIST_BIN_BITS-1:0] cmpBin;
    logic [`COUNT_BITS-1:0]    maxCount;
    logic [`HIST_BIN_BITS-1:0] maxBin;
    logic                      better;

    assign lastBin   = scanBin == '1;
    assign lastPixel = scanPixel == `PIXEL_BITS'(`HIST_PIXELS - 1);

    assign fifoPop = fifoValid && (state == stIdle || state == stCount);

    assign oldCount  = fwdHit ? fwdData : ramRdData;
    assign ramRdEn   = s1Valid || state == stScan;
    assign ramRdAddr = (state == stScan) ? {scanPixel, scanBin} : s1Addr;
    assign ramWrEn   = state == stClear || s2Valid || cmpValid;

    always_comb begin
        ramWrAddr = s2Addr;
        ramWrData = '0;
        if (state == stClear) begin
            ramWrAddr = {scanPixel, scanBin};
        end else if (cmpValid) begin
            ramWrAddr = {scanPixel, cmpBin};  // zero the bin just compared
        end else if (s2Valid) begin
            ramWrData = (oldCount == '1) ? oldCount : oldCount + 1'b1;
        end
    end

    // strictly greater, so the lowest bin wins a tie
    assign better   = cmpValid && ramRdData > maxCount;
    assign resValid = state == stEmit && !resFull;
    assign resPixel = scanPixel;
    assign resBin   = better ? cmpBin : maxBin;
    assign resCount = better ? ramRdData : maxCount;

    always_ff @(posedge clk) begin
        s1Addr  <= {fifoPixel, fifoTdc[`TDC_BITS-1 -: `HIST_BIN_BITS]};
        s2Addr  <= s1Addr;
        fwdData <= ramWrData;
        cmpBin  <= scanBin;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= stClear;
            s1Valid   <= 1'b0;
            s2Valid   <= 1'b0;
            fwdHit    <= 1'b0;
            cmpValid  <= 1'b0;
            scanPixel <= '0;
            scanBin   <= '0;
            maxCount  <= '0;
            maxBin    <= '0;
        end else begin
            s1Valid  <= fifoPop && fifoOp == opSample;
            s2Valid  <= s1Valid;
            fwdHit   <= s1Valid && s2Valid && s1Addr == s2Addr;
            cmpValid <= state == stScan;
            if (better) begin
                maxCount <= ramRdData;
                maxBin   <= cmpBin;
            end
            case (state)
                stClear: begin
                    scanBin <= scanBin + 1'b1;
                    if (lastBin) begin
                        scanPixel <= scanPixel + 1'b1;
                        if (lastPixel) begin
                            scanPixel <= '0;
                            state     <= stIdle;
                        end
                    end
                end
                stIdle, stCount: begin
                    if (fifoPop && fifoOp == opFrameEnd) begin
                        state <= stDrain;
                    end else if (fifoPop) begin
                        state <= stCount;
                    end else if (!s1Valid && !s2Valid) begin
                        state <= stIdle;
                    end
                end
                stDrain: begin
                    if (!s1Valid && !s2Valid) begin
                        state <= stScan;
                    end
                end
                stScan: begin
                    scanBin <= scanBin + 1'b1;  // wraps to bin 0 for the next pixel
                    if (lastBin) begin
                        state <= stEmit;
                    end
                end
                stEmit: begin
                    if (!resFull) begin
                        maxCount <= '0;
                        maxBin   <= '0;
                        if (lastPixel) begin
                            scanPixel <= '0;
                            state     <= stIdle;
                        end else begin
                            scanPixel <= scanPixel + 1'b1;
                            state     <= stScan;
                        end
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

endmodule

// File: hw/histCfg.svh
`ifndef HIST_CFG_SVH
`define HIST_CFG_SVH

// sensor array
`define HIST_PIXELS 4
`define PIXEL_BITS 2

// timestamp and histogram shape
`define TDC_BITS 10
`define HIST_BIN_BITS 4     // top tdc bits, 16 bins per pixel
`define COUNT_BITS 6        // bin counters saturate at all ones

// ram address is {pixel, bin}
`define RAM_ADDR_BITS (`PIXEL_BITS + `HIST_BIN_BITS)

// link credits
`define IN_CREDITS 4        // also the receive fifo depth
`define OUT_CREDITS 2       // initial credit granted by the result receiver

`endif

// File: hw/histPkg.sv
package histPkg;

    // histogram engine states
    typedef enum logic [2:0] {
        stClear = 3'd0,  // zeroing the ram after reset
        stIdle  = 3'd1,
        stCount = 3'd2,  // samples in the increment pipeline
        stDrain = 3'd3,  // frame end seen, waiting for the last write
        stScan  = 3'd4,  // reading one pixel's bins
        stEmit  = 3'd5   // presenting the peak of that pixel
    } buildState;

endpackage

// File: hw/histRam.sv
`include "histCfg.svh"

module histRam (
    input  logic                      clk,
    input  logic                      ramWrEn,
    input  logic [`RAM_ADDR_BITS-1:0] ramWrAddr,
    input  logic [`COUNT_BITS-1:0]    ramWrData,
    input  logic                      ramRdEn,
    input  logic [`RAM_ADDR_BITS-1:0] ramRdAddr,
    output logic [`COUNT_BITS-1:0]    ramRdData
);
    // one count per {pixel, bin}
    logic [`COUNT_BITS-1:0] mem [2**`RAM_ADDR_BITS];

    always_ff @(posedge clk) begin
        if (ramWrEn) begin
            mem[ramWrAddr] <= ramWrData;
        end
    end

    // read first: a read and a write to one address in the same cycle
    // returns the old count, the builder forwards around this
    always_ff @(posedge clk) begin
        if (ramRdEn) begin
            ramRdData <= mem[ramRdAddr];
        end
    end

endmodule

// File: hw/histTop.sv
`include "histCfg.svh"

module histTop import linkPkg::*; (
    input  logic                      clk,
    input  logic                      res,
    // timestamp link in
    input  logic                      inValid,
    input  linkOp                     inOp,
    input  logic [`PIXEL_BITS-1:0]    inPixel,
    input  logic [`TDC_BITS-1:0]      inTdc,
    output logic                      inCredit,
    // peak result link out
    output logic                      outValid,
    output logic [`PIXEL_BITS-1:0]    outPixel,
    output logic [`HIST_BIN_BITS-1:0] outBin,
    output logic [`COUNT_BITS-1:0]    outCount,
    input  logic                      outCredit
);
    logic                      fifoValid;
    linkOp                     fifoOp;
    logic [`PIXEL_BITS-1:0]    fifoPixel;
    logic [`TDC_BITS-1:0]      fifoTdc;
    logic                      fifoPop;
    logic                      ramRdEn;
    logic [`RAM_ADDR_BITS-1:0] ramRdAddr;
    logic [`COUNT_BITS-1:0]    ramRdData;
    logic                      ramWrEn;
    logic [`RAM_ADDR_BITS-1:0] ramWrAddr;
    logic [`COUNT_BITS-1:0]    ramWrData;
    logic                      resValid;
    logic [`PIXEL_BITS-1:0]    resPixel;
    logic [`HIST_BIN_BITS-1:0] resBin;
    logic [`COUNT_BITS-1:0]    resCount;
    logic                      resFull;

    sampleIngress ingress (
        .clk(clk), .res(res), .inValid(inValid), .inOp(inOp), .inPixel(inPixel),
        .inTdc(inTdc), .inCredit(inCredit), .fifoValid(fifoValid), .fifoOp(fifoOp),
        .fifoPixel(fifoPixel), .fifoTdc(fifoTdc), .fifoPop(fifoPop)
    );

    histBuilder builder (
        .clk(clk), .res(res), .fifoValid(fifoValid), .fifoOp(fifoOp),
        .fifoPixel(fifoPixel), .fifoTdc(fifoTdc), .fifoPop(fifoPop),
        .ramRdEn(ramRdEn), .ramRdAddr(ramRdAddr), .ramRdData(ramRdData),
        .ramWrEn(ramWrEn), .ramWrAddr(ramWrAddr), .ramWrData(ramWrData),
        .resValid(resValid), .resPixel(resPixel), .resBin(resBin),
        .resCount(resCount), .resFull(resFull)
    );

    histRam ram (
        .clk(clk), .ramWrEn(ramWrEn), .ramWrAddr(ramWrAddr), .ramWrData(ramWrData),
        .ramRdEn(ramRdEn), .ramRdAddr(ramRdAddr), .ramRdData(ramRdData)
    );

    peakEgress egress (
        .clk(clk), .res(res), .resValid(resValid), .resPixel(resPixel),
        .resBin(resBin), .resCount(resCount), .resFull(resFull),
        .outValid(outValid), .outPixel(outPixel), .outBin(outBin),
        .outCount(outCount), .outCredit(outCredit)
    );

endmodule

// File: hw/linkPkg.sv
package linkPkg;

    // word types on the timestamp input link
    typedef enum logic [0:0] {
        opSample   = 1'b0,  // pixel number plus tdc code
        opFrameEnd = 1'b1   // closes the frame, starts the peak scan
    } linkOp;

endpackage

// File: hw/peakEgress.sv
`include "histCfg.svh"

module peakEgress (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      resValid,
    input  logic [`PIXEL_BITS-1:0]    resPixel,
    input  logic [`HIST_BIN_BITS-1:0] resBin,
    input  logic [`COUNT_BITS-1:0]    resCount,
    output logic                      resFull,
    output logic                      outValid,
    output logic [`PIXEL_BITS-1:0]    outPixel,
    output logic [`HIST_BIN_BITS-1:0] outBin,
    output logic [`COUNT_BITS-1:0]    outCount,
    input  logic                      outCredit
);
    // two entry result buffer
    logic [`PIXEL_BITS-1:0]    pixelBuf [2];
    logic [`HIST_BIN_BITS-1:0] binBuf   [2];
    logic [`COUNT_BITS-1:0]    countBuf [2];
    logic                      wrSel;
    logic                      rdSel;
    logic [1:0]                held;
    logic [$clog2(`OUT_CREDITS+1)-1:0] credits;

    assign resFull  = held == 2'd2;
    assign outValid = held != 2'd0 && credits != '0;  // one credit per send
    assign outPixel = pixelBuf[rdSel];
    assign outBin   = binBuf[rdSel];
    assign outCount = countBuf[rdSel];

    always_ff @(posedge clk) begin
        if (resValid) begin
            pixelBuf[wrSel] <= resPixel;
            binBuf[wrSel]   <= resBin;
            countBuf[wrSel] <= resCount;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wrSel   <= 1'b0;
            rdSel   <= 1'b0;
            held    <= 2'd0;
            credits <= ($clog2(`OUT_CREDITS+1))'(`OUT_CREDITS);
        end else begin
            if (resValid) wrSel <= !wrSel;
            if (outValid) rdSel <= !rdSel;
            case ({resValid, outValid})
                2'b10:   held <= held + 1'b1;
                2'b01:   held <= held - 1'b1;
                default: held <= held;
            endcase
            case ({outValid, outCredit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;   // send and return cancel
            endcase
        end
    end

endmodule

// File: hw/sampleIngress.sv
`include "histCfg.svh"

module sampleIngress import linkPkg::*; (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   inValid,
    input  linkOp                  inOp,
    input  logic [`PIXEL_BITS-1:0] inPixel,
    input  logic [`TDC_BITS-1:0]   inTdc,
    output logic                   inCredit,
    output logic                   fifoValid,
    output linkOp                  fifoOp,
    output logic [`PIXEL_BITS-1:0] fifoPixel,
    output logic [`TDC_BITS-1:0]   fifoTdc,
    input  logic                   fifoPop
);
    linkOp                            opMem    [`IN_CREDITS];
    logic [`PIXEL_BITS-1:0]           pixelMem [`IN_CREDITS];
    logic [`TDC_BITS-1:0]             tdcMem   [`IN_CREDITS];
    logic [$clog2(`IN_CREDITS)-1:0]   wrPtr;
    logic [$clog2(`IN_CREDITS)-1:0]   rdPtr;
    logic [$clog2(`IN_CREDITS+1)-1:0] used;
    logic                             pop;

    assign pop       = fifoPop && fifoValid;
    assign fifoValid = used != '0;
    assign fifoOp    = opMem[rdPtr];
    assign fifoPixel = pixelMem[rdPtr];
    assign fifoTdc   = tdcMem[rdPtr];

    // sender holds credits, so a write never finds the fifo full
    always_ff @(posedge clk) begin
        if (inValid) begin
            opMem[wrPtr]    <= inOp;
            pixelMem[wrPtr] <= inPixel;
            tdcMem[wrPtr]   <= inTdc;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            used     <= '0;
            inCredit <= 1'b0;
        end else begin
            inCredit <= pop;  // one credit back per word taken
            if (inValid) begin
                if (wrPtr == ($clog2(`IN_CREDITS))'(`IN_CREDITS - 1)) begin
                    wrPtr <= '0;
                end else begin
                    wrPtr <= wrPtr + 1'b1;
                end
            end
            if (pop) begin
                if (rdPtr == ($clog2(`IN_CREDITS))'(`IN_CREDITS - 1)) begin
                    rdPtr <= '0;
                end else begin
                    rdPtr <= rdPtr + 1'b1;
                end
            end
            case ({inValid, pop})
                2'b10:   used <= used + 1'b1;
                2'b01:   used <= used - 1'b1;
                default: used <= used;
            endcase
        end
    end

endmodule

// File: project.f
+incdir+hw
hw/linkPkg.sv
hw/histPkg.sv
hw/sampleIngress.sv
hw/histRam.sv
hw/histBuilder.sv
hw/peakEgress.sv
hw/histTop.sv
bench/histTb.sv

// File: run.sh
#!/bin/sh
# compile and run the histogram testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module histTb -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/VhistTb)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOut" | grep -qx "PASS: all tests"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
